// ==== files.f ====
+incdir+sim
src/rename_pkg.sv
src/map_table_regs.sv
src/operand_lookup.sv
src/checkpoint_store.sv
src/rename_map_top.sv
sim/rename_map_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rename map testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

{ verilator --binary --timing --assert -f files.f --top-module rename_map_tb &&
  ./obj_dir/Vrename_map_tb; } > "$LOG" 2>&1 ||
  echo "build or simulation exited with an error" >> "$LOG"

cat "$LOG"

grep -q "RESULT: FAIL" "$LOG" && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" "$LOG" || { echo "simulation did not report a result"; exit 1; }
echo "simulation passed"
exit 0

// ==== sim/rename_model.svh ====
/*
 * testbench reference model of the rename map table and checkpoint
 * Fibonacci LFSR random source
 */

`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// ============================================================================
// random source
// ============================================================================
logic [31:0] lfsr_state;

// taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one step per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
        lfsr_state = lfsr_next(lfsr_state);
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

// ============================================================================
// model state
// ============================================================================
logic [PHYS_IDX_W-1:0] m_phys       [ARCH_REGS];
logic                  m_ready      [ARCH_REGS];
logic [PHYS_IDX_W-1:0] m_ckpt_phys  [ARCH_REGS];
logic                  m_ckpt_ready [ARCH_REGS];
logic                  m_ckpt_held;

task automatic model_reset();
    for (int i = 0; i < ARCH_REGS; i++) begin
        m_phys[i]       = PHYS_IDX_W'(i);
        m_ready[i]      = 1'b1;
        m_ckpt_phys[i]  = PHYS_IDX_W'(i);
        m_ckpt_ready[i] = 1'b1;
    end
    m_ckpt_held = 1'b0;
endtask

// any valid writeback port carries this tag
function automatic logic tag_written(input logic [PHYS_IDX_W-1:0] tag);
    logic hit;
    hit = 1'b0;
    for (int w = 0; w < WB_WIDTH; w++) begin
        if (wb[w].valid && (wb[w].phys == tag)) begin
            hit = 1'b1;
        end
    end
    return hit;
endfunction

// {tag, ready} seen by a source read this cycle
function automatic logic [PHYS_IDX_W:0] expect_src(input logic [ARCH_IDX_W-1:0] rs);
    return {m_phys[rs], m_ready[rs] | tag_written(m_phys[rs])};
endfunction

function automatic logic [PHYS_IDX_W-1:0] expect_old_phys();
    if (restore && m_ckpt_held) begin
        return m_ckpt_phys[dispatch.arch_dst];
    end
    return m_phys[dispatch.arch_dst];
endfunction

// state change at a rising edge, from the inputs of the ending cycle
task automatic model_update();
    logic [PHYS_IDX_W-1:0] n_phys  [ARCH_REGS];
    logic                  n_ready [ARCH_REGS];
    logic                  do_restore;
    logic                  do_rename;
    do_restore = restore && m_ckpt_held;
    do_rename  = !do_restore && dispatch.valid && (dispatch.arch_dst != ZERO_REG);
    for (int i = 0; i < ARCH_REGS; i++) begin
        if (do_restore) begin
            n_phys[i]  = m_ckpt_phys[i];
            n_ready[i] = m_ckpt_ready[i] || tag_written(m_ckpt_phys[i]) ||
                         ((m_ckpt_phys[i] == m_phys[i]) && m_ready[i]);
        end else begin
            n_phys[i]  = m_phys[i];
            n_ready[i] = m_ready[i];
        end
    end
    if (do_rename) begin
        n_phys[dispatch.arch_dst]  = dispatch.phys_new;
        n_ready[dispatch.arch_dst] = 1'b0;
    end
    // broadcast, the freshly renamed entry keeps waiting
    for (int i = 0; i < ARCH_REGS; i++) begin
        if (tag_written(n_phys[i]) && !(do_rename && (dispatch.arch_dst == ARCH_IDX_W'(i)))) begin
            n_ready[i] = 1'b1;
        end
    end
    if (do_restore) begin
        m_ckpt_held = 1'b0;
    end else if (dispatch.valid && dispatch.is_branch) begin
        m_ckpt_phys  = n_phys;
        m_ckpt_ready = n_ready;
        m_ckpt_held  = 1'b1;
    end
    m_phys  = n_phys;
    m_ready = n_ready;
endtask

`endif

// ==== sim/rename_map_tb.sv ====
/*
 * rename map testbench
 * directed reset, rename, writeback and checkpoint tests,
 * random mix checked against the reference model
 */

`timescale 1ns/10ps

module rename_map_tb
    import rename_pkg::*;
();

    localparam int          WB_WIDTH      = 2;
    localparam logic [31:0] LFSR_SEED     = 32'h1e168a06;
    localparam int          RANDOM_CYCLES = 2000;
    localparam int          MAX_TIME_NS   = 100000;

    logic                  clock;
    logic                  reset;
    lookup_req_t           lookup_req;
    lookup_rsp_t           lookup_rsp;
    dispatch_req_t         dispatch;
    logic [PHYS_IDX_W-1:0] old_phys;
    wb_req_t               wb [WB_WIDTH];
    logic                  restore;
    logic                  ckpt_valid;

    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;
    int test_start_errors;

    `include "rename_model.svh"

    rename_map_top #(
        .WB_WIDTH (WB_WIDTH)
    ) u_rename_map_top (
        .clock        (clock),
        .reset        (reset),
        .lookup_req_i (lookup_req),
        .lookup_rsp_o (lookup_rsp),
        .dispatch_i   (dispatch),
        .old_phys_o   (old_phys),
        .wb_i         (wb),
        .restore_i    (restore),
        .ckpt_valid_o (ckpt_valid)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // overall limit on the run
    initial begin
        #(MAX_TIME_NS);
        $display("simulation timed out before all tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    // ========================================================================
    // drive and check helpers
    // ========================================================================
    task automatic set_idle();
        lookup_req = '0;
        dispatch   = '0;
        restore    = 1'b0;
        for (int w = 0; w < WB_WIDTH; w++) begin
            wb[w] = '0;
        end
    endtask

    task automatic drive_dispatch(input int dst, input int tag, input logic branch);
        dispatch.valid     = 1'b1;
        dispatch.arch_dst  = ARCH_IDX_W'(dst);
        dispatch.phys_new  = PHYS_IDX_W'(tag);
        dispatch.is_branch = branch;
    endtask

    task automatic drive_wb(input int port, input int tag);
        wb[port].valid = 1'b1;
        wb[port].phys  = PHYS_IDX_W'(tag);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got == exp) else begin
            error_count++;
            $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_lookup(input int p1, input int r1, input int p2, input int r2);
        check_value("rs1 tag", 32'(lookup_rsp.rs1_phys), p1);
        check_value("rs1 ready", 32'(lookup_rsp.rs1_ready), r1);
        check_value("rs2 tag", 32'(lookup_rsp.rs2_phys), p2);
        check_value("rs2 ready", 32'(lookup_rsp.rs2_ready), r2);
    endtask

    // compare outputs with the model just before the edge
    task automatic settle();
        #6;
        check_value("rs1 lookup", 32'({lookup_rsp.rs1_phys, lookup_rsp.rs1_ready}),
                    32'(expect_src(lookup_req.rs1)));
        check_value("rs2 lookup", 32'({lookup_rsp.rs2_phys, lookup_rsp.rs2_ready}),
                    32'(expect_src(lookup_req.rs2)));
        check_value("old_phys_o", 32'(old_phys), 32'(expect_old_phys()));
        check_value("ckpt_valid_o", 32'(ckpt_valid), 32'(m_ckpt_held));
    endtask

    // model follows the clock edge and inputs return to idle at the drive point
    task automatic advance();
        @(posedge clock);
        model_update();
        #1;
        set_idle();
    endtask

    task automatic step();
        settle();
        advance();
    endtask

    task automatic wait_ckpt_valid(input logic level, input int max_cycles);
        int n;
        n = 0;
        while ((ckpt_valid != level) && (n < max_cycles)) begin
            step();
            n++;
        end
        check_count++;
        assert (ckpt_valid == level) else begin
            error_count++;
            $display("ckpt_valid_o did not reach %0b within %0d cycles at %0t",
                     level, max_cycles, $time);
        end
    endtask

    task automatic begin_test();
        test_start_errors = error_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %-10s %s, %0d errors", name,
                 (error_count == test_start_errors) ? "ok" : "failed",
                 error_count - test_start_errors);
    endtask

    // ========================================================================
    // tests
    // ========================================================================
    task automatic test_reset();
        begin_test();
        for (int r = 0; r < ARCH_REGS; r += 2) begin
            lookup_req.rs1 = ARCH_IDX_W'(r);
            lookup_req.rs2 = ARCH_IDX_W'(r + 1);
            settle();
            check_lookup(r, 1, r + 1, 1);
            check_value("ckpt_valid_o after reset", 32'(ckpt_valid), 0);
            advance();
        end
        end_test("reset");
    endtask

    task automatic test_rename();
        begin_test();
        drive_dispatch(5, 40, 1'b0);
        settle();
        check_value("rename old tag", 32'(old_phys), 5);
        advance();
        lookup_req.rs1 = 5;
        drive_dispatch(0, 41, 1'b0);
        settle();
        check_lookup(40, 0, 0, 1);
        advance();
        settle();
        check_lookup(0, 1, 0, 1);
        advance();
        end_test("rename");
    endtask

    task automatic test_writeback();
        begin_test();
        drive_dispatch(7, 40, 1'b0);
        step();
        // forwarding plus a rename racing its own writeback
        lookup_req.rs1 = 5;
        lookup_req.rs2 = 7;
        drive_dispatch(9, 42, 1'b0);
        drive_wb(0, 40);
        drive_wb(1, 42);
        settle();
        check_lookup(40, 1, 40, 1);
        advance();
        lookup_req.rs1 = 5;
        lookup_req.rs2 = 7;
        settle();
        check_lookup(40, 1, 40, 1);
        advance();
        lookup_req.rs1 = 9;
        settle();
        check_lookup(42, 0, 0, 1);
        advance();
        end_test("writeback");
    endtask

    task automatic test_save();
        begin_test();
        drive_dispatch(10, 50, 1'b1);
        settle();
        check_value("ckpt_valid_o before save", 32'(ckpt_valid), 0);
        advance();
        wait_ckpt_valid(1'b1, 4);
        drive_dispatch(10, 51, 1'b0);
        step();
        end_test("save");
    endtask

    task automatic test_restore();
        begin_test();
        // restore drops the dispatch and the saved tag's writeback merges ready
        restore = 1'b1;
        drive_dispatch(11, 52, 1'b0);
        drive_wb(0, 50);
        settle();
        check_value("restore old tag", 32'(old_phys), 11);
        advance();
        lookup_req.rs1 = 10;
        lookup_req.rs2 = 11;
        settle();
        check_lookup(50, 1, 11, 1);
        check_value("ckpt_valid_o after restore", 32'(ckpt_valid), 0);
        advance();
        // no checkpoint held so the dispatch still renames
        restore = 1'b1;
        drive_dispatch(11, 53, 1'b0);
        step();
        lookup_req.rs1 = 10;
        lookup_req.rs2 = 11;
        settle();
        check_lookup(50, 1, 53, 0);
        advance();
        end_test("restore");
    endtask

    task automatic test_random();
        begin_test();
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            lookup_req.rs1     = ARCH_IDX_W'(take_bits(ARCH_IDX_W));
            lookup_req.rs2     = ARCH_IDX_W'(take_bits(ARCH_IDX_W));
            dispatch.valid     = (take_bits(2) != 0);
            dispatch.arch_dst  = ARCH_IDX_W'(take_bits(ARCH_IDX_W));
            dispatch.phys_new  = PHYS_IDX_W'(take_bits(PHYS_IDX_W));
            dispatch.is_branch = (take_bits(3) == 0);
            for (int w = 0; w < WB_WIDTH; w++) begin
                wb[w].valid = (take_bits(1) != 0);
                wb[w].phys  = PHYS_IDX_W'(take_bits(PHYS_IDX_W));
            end
            restore = (take_bits(4) == 0);
            step();
        end
        end_test("random");
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin
        lfsr_state = LFSR_SEED;
        set_idle();
        reset = 1'b1;
        model_reset();
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        test_reset();
        test_rename();
        test_writeback();
        test_save();
        test_restore();
        test_random();

        $display("tests run: %0d, checks: %0d, errors: %0d",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== src/rename_map_top.sv ====
/*
 * rename map top level
 * map table registers, operand lookup, checkpoint store
 */

`timescale 1ns/10ps

module rename_map_top
    import rename_pkg::*;
#(
    parameter int WB_WIDTH = 2
) (
    input  logic                  clock,
    input  logic                  reset,

    // source query, answered in the same cycle
    input  lookup_req_t           lookup_req_i,
    output lookup_rsp_t           lookup_rsp_o,

    // destination rename
    input  dispatch_req_t         dispatch_i,
    output logic [PHYS_IDX_W-1:0] old_phys_o,

    // completion broadcast
    input  wb_req_t               wb_i [WB_WIDTH],

    // branch recovery
    input  logic                  restore_i,
    output logic                  ckpt_valid_o
);

    // ========================================================================
    // internal wiring
    // ========================================================================
    map_entry_t table_w      [ARCH_REGS];
    map_entry_t next_table_w [ARCH_REGS];
    map_entry_t ckpt_table_w [ARCH_REGS];
    logic       restore_valid_w;

    // mapping table and its next state
    map_table_regs #(
        .WB_WIDTH (WB_WIDTH)
    ) u_map_table_regs (
        .clock           (clock),
        .reset           (reset),
        .dispatch_i      (dispatch_i),
        .wb_i            (wb_i),
        .restore_valid_i (restore_valid_w),
        .ckpt_table_i    (ckpt_table_w),
        .table_o         (table_w),
        .next_table_o    (next_table_w),
        .old_phys_o      (old_phys_o)
    );

    // reads the current table, forwards same-cycle writebacks
    operand_lookup #(
        .WB_WIDTH (WB_WIDTH)
    ) u_operand_lookup (
        .lookup_req_i (lookup_req_i),
        .table_i      (table_w),
        .wb_i         (wb_i),
        .lookup_rsp_o (lookup_rsp_o)
    );

    // captures the next-state table on a branch dispatch
    checkpoint_store u_checkpoint_store (
        .clock           (clock),
        .reset           (reset),
        .dispatch_i      (dispatch_i),
        .restore_i       (restore_i),
        .next_table_i    (next_table_w),
        .ckpt_table_o    (ckpt_table_w),
        .restore_valid_o (restore_valid_w),
        .ckpt_valid_o    (ckpt_valid_o)
    );

endmodule

// ==== src/checkpoint_store.sv ====
/*
 * single-level branch checkpoint
 * saved table copy, held/empty state, restore qualification
 */

`timescale 1ns/10ps

module checkpoint_store
    import rename_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  dispatch_req_t dispatch_i,
    input  logic          restore_i,
    input  map_entry_t    next_table_i [ARCH_REGS],
    output map_entry_t    ckpt_table_o [ARCH_REGS],
    output logic          restore_valid_o,
    output logic          ckpt_valid_o
);

    ckpt_state_e state_q;
    map_entry_t  ckpt_q [ARCH_REGS];
    logic        save_en;

    // restore only means something with a checkpoint in hand
    assign restore_valid_o = restore_i && (state_q == CKPT_HELD);

    // save after the branch's own rename, never on a restore cycle
    assign save_en = dispatch_i.valid && dispatch_i.is_branch && !restore_valid_o;

    // ========================================================================
    // state
    // ========================================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= CKPT_EMPTY;
        end else if (restore_valid_o) begin
            state_q <= CKPT_EMPTY;
        end else if (save_en) begin
            // a newer branch overwrites the older checkpoint
            state_q <= CKPT_HELD;
        end
    end

    // table copy
    always_ff @(posedge clock) begin
        if (save_en) begin
            ckpt_q <= next_table_i;
        end
    end

    assign ckpt_table_o = ckpt_q;
    assign ckpt_valid_o = (state_q == CKPT_HELD);

endmodule

// ==== src/operand_lookup.sv ====
/*
 * source operand lookup
 * per-entry writeback forward vector, tag and ready for rs1 and rs2
 */

`timescale 1ns/10ps

module operand_lookup
    import rename_pkg::*;
#(
    parameter int WB_WIDTH = 2
) (
    input  lookup_req_t lookup_req_i,
    input  map_entry_t  table_i [ARCH_REGS],
    input  wb_req_t     wb_i    [WB_WIDTH],
    output lookup_rsp_t lookup_rsp_o
);

    // entry i holds a tag being written back this cycle
    logic [ARCH_REGS-1:0] wb_fwd;

    // ========================================================================
    // writeback forwarding
    // ========================================================================
    // the table only sees a writeback at the next edge,
    // so a same-cycle reader needs the tag match here
    always_comb begin
        wb_fwd = '0;
        for (int w = 0; w < WB_WIDTH; w++) begin
            if (wb_i[w].valid) begin
                for (int j = 0; j < ARCH_REGS; j++) begin
                    if (table_i[j].phys == wb_i[w].phys) begin
                        wb_fwd[j] = 1'b1;
                    end
                end
            end
        end
    end

    // ========================================================================
    // table read
    // ========================================================================
    always_comb begin
        // rs1
        lookup_rsp_o.rs1_phys  = table_i[lookup_req_i.rs1].phys;
        lookup_rsp_o.rs1_ready = table_i[lookup_req_i.rs1].ready |
                                 wb_fwd[lookup_req_i.rs1];
        // rs2
        lookup_rsp_o.rs2_phys  = table_i[lookup_req_i.rs2].phys;
        lookup_rsp_o.rs2_ready = table_i[lookup_req_i.rs2].ready |
                                 wb_fwd[lookup_req_i.rs2];
    end

endmodule

// ==== src/map_table_regs.sv ====
/*
 * rename map table registers
 * identity reset, next state for restore, rename and writeback,
 * previous tag select for the dispatched destination
 */

`timescale 1ns/10ps

module map_table_regs
    import rename_pkg::*;
#(
    parameter int WB_WIDTH = 2
) (
    input  logic                  clock,
    input  logic                  reset,
    input  dispatch_req_t         dispatch_i,
    input  wb_req_t               wb_i         [WB_WIDTH],
    input  logic                  restore_valid_i,
    input  map_entry_t            ckpt_table_i [ARCH_REGS],
    output map_entry_t            table_o      [ARCH_REGS],
    output map_entry_t            next_table_o [ARCH_REGS],
    output logic [PHYS_IDX_W-1:0] old_phys_o
);

    map_entry_t           table_q    [ARCH_REGS];
    map_entry_t           next_table [ARCH_REGS];

    // dispatch actually renames this cycle
    logic                 rename_en;
    // a writeback this cycle carries the checkpoint tag of entry i
    logic [ARCH_REGS-1:0] ckpt_wb_hit;

    // restore wins over dispatch, r0 is never renamed
    assign rename_en = dispatch_i.valid && !restore_valid_i &&
                       (dispatch_i.arch_dst != ZERO_REG);

    always_comb begin
        ckpt_wb_hit = '0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            for (int w = 0; w < WB_WIDTH; w++) begin
                if (wb_i[w].valid && (wb_i[w].phys == ckpt_table_i[i].phys)) begin
                    ckpt_wb_hit[i] = 1'b1;
                end
            end
        end
    end

    // ========================================================================
    // next state
    // ========================================================================
    always_comb begin
        next_table = table_q;

        if (restore_valid_i) begin
            // reload tags from the checkpoint
            for (int i = 0; i < ARCH_REGS; i++) begin
                next_table[i].phys  = ckpt_table_i[i].phys;
                // ready if saved ready, still ready live on the same tag,
                // or completing right now
                next_table[i].ready = ckpt_table_i[i].ready ||
                                      ((ckpt_table_i[i].phys == table_q[i].phys) &&
                                       table_q[i].ready) ||
                                      ckpt_wb_hit[i];
            end
        end else if (rename_en) begin
            // new tag, value not produced yet
            next_table[dispatch_i.arch_dst].phys  = dispatch_i.phys_new;
            next_table[dispatch_i.arch_dst].ready = 1'b0;
        end

        // writeback broadcast against the post-rename tags
        for (int w = 0; w < WB_WIDTH; w++) begin
            for (int j = 0; j < ARCH_REGS; j++) begin
                if (wb_i[w].valid && (next_table[j].phys == wb_i[w].phys) &&
                    !(rename_en && (dispatch_i.arch_dst == ARCH_IDX_W'(j)))) begin
                    next_table[j].ready = 1'b1;
                end
            end
        end
    end

    // ========================================================================
    // table registers
    // ========================================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map, everything committed
            for (int i = 0; i < ARCH_REGS; i++) begin
                table_q[i].phys  <= PHYS_IDX_W'(i);
                table_q[i].ready <= 1'b1;
            end
        end else begin
            table_q <= next_table;
        end
    end

    // previous tag of the destination
    // during a restore the freed tag is the one the checkpoint held
    always_comb begin
        if (restore_valid_i) begin
            old_phys_o = ckpt_table_i[dispatch_i.arch_dst].phys;
        end else begin
            old_phys_o = table_q[dispatch_i.arch_dst].phys;
        end
    end

    assign table_o      = table_q;
    assign next_table_o = next_table;

endmodule

// ==== src/rename_pkg.sv ====
/*
 * rename map shared definitions
 * table sizes, map entry, dispatch, writeback and lookup structs,
 * checkpoint state enum
 */

package rename_pkg;

    // ========================================================================
    // table sizes
    // ========================================================================
    localparam int ARCH_REGS  = 32;
    localparam int PHYS_REGS  = 64;
    localparam int ARCH_IDX_W = $clog2(ARCH_REGS);
    localparam int PHYS_IDX_W = $clog2(PHYS_REGS);

    // architectural r0 keeps its identity mapping
    localparam logic [ARCH_IDX_W-1:0] ZERO_REG = '0;

    // ========================================================================
    // struct types
    // ========================================================================
    // one table entry, tag plus value-ready flag
    typedef struct packed {
        logic [PHYS_IDX_W-1:0] phys;
        logic                  ready;
    } map_entry_t;

    // single-slot rename request from dispatch
    typedef struct packed {
        logic                  valid;
        logic [ARCH_IDX_W-1:0] arch_dst;
        logic [PHYS_IDX_W-1:0] phys_new;
        logic                  is_branch;
    } dispatch_req_t;

    // one writeback port
    typedef struct packed {
        logic                  valid;
        logic [PHYS_IDX_W-1:0] phys;
    } wb_req_t;

    // source operand query
    typedef struct packed {
        logic [ARCH_IDX_W-1:0] rs1;
        logic [ARCH_IDX_W-1:0] rs2;
    } lookup_req_t;

    typedef struct packed {
        logic [PHYS_IDX_W-1:0] rs1_phys;
        logic                  rs1_ready;
        logic [PHYS_IDX_W-1:0] rs2_phys;
        logic                  rs2_ready;
    } lookup_rsp_t;

    // single-level checkpoint occupancy
    typedef enum logic [0:0] {
        CKPT_EMPTY = 1'b0,
        CKPT_HELD  = 1'b1
    } ckpt_state_e;

endpackage
